// File: design/core_id_ex_top.sv
`timescale 1ns/1ns
`default_nettype none

module core_id_ex_top #(
  parameter rv_core_pkg::xlen_t RESET_PC = '0
) (
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  inst_valid_i,
  input  rv_core_pkg::xlen_t    inst_addr_i,
  input  rv_core_pkg::inst_t    inst_data_i,
  input  logic                  ex_stall_i,
  output logic                  inst_ready_o,
  output logic                  wb_valid_o,
  output rv_core_pkg::reg_idx_t wb_rd_o,
  output rv_core_pkg::xlen_t    wb_data_o,
  output logic                  redirect_valid_o,
  output rv_core_pkg::xlen_t    redirect_pc_o,
  output logic                  trap_valid_o,
  output rv_core_pkg::xlen_t    trap_pc_o
);

  // decode side
  logic                  id_valid;
  rv_core_pkg::xlen_t    id_pc;
  rv_core_pkg::inst_t    id_inst;
  rv_core_pkg::reg_idx_t id_rs1_idx;
  rv_core_pkg::reg_idx_t id_rs2_idx;
  rv_core_pkg::reg_idx_t id_rd_idx;
  rv_core_pkg::xlen_t    id_imm;
  rv_core_pkg::xlen_t    id_rs1_data;
  rv_core_pkg::xlen_t    id_rs2_data;
  rv_core_pkg::alu_op_e  id_alu_op;
  rv_core_pkg::pc_op_e   id_pc_op;
  logic                  id_illegal;

  // execute side
  logic                  ex_valid;
  rv_core_pkg::xlen_t    ex_pc;
  rv_core_pkg::reg_idx_t ex_rd_idx;
  rv_core_pkg::xlen_t    ex_imm;
  rv_core_pkg::xlen_t    ex_rs1_data;
  rv_core_pkg::xlen_t    ex_rs2_data;
  rv_core_pkg::alu_op_e  ex_alu_op;
  rv_core_pkg::pc_op_e   ex_pc_op;
  logic                  ex_illegal;

  // pipeline control
  logic hold;
  logic flush;

  id_stage u_id_stage (
    .inst_valid_i (inst_valid_i),
    .inst_addr_i  (inst_addr_i),
    .inst_data_i  (inst_data_i),
    .valid_o      (id_valid),
    .pc_o         (id_pc),
    .inst_o       (id_inst),
    .rs1_idx_o    (id_rs1_idx),
    .rs2_idx_o    (id_rs2_idx),
    .rd_idx_o     (id_rd_idx),
    .imm_o        (id_imm),
    .alu_op_o     (id_alu_op),
    .pc_op_o      (id_pc_op),
    .illegal_o    (id_illegal)
  );

  // written straight from execute, no separate writeback stage
  reg_file u_reg_file (
    .clk        (clk),
    .rst_i      (rst_i),
    .rs1_idx_i  (id_rs1_idx),
    .rs2_idx_i  (id_rs2_idx),
    .we_i       (wb_valid_o),
    .wd_idx_i   (wb_rd_o),
    .wd_data_i  (wb_data_o),
    .rs1_data_o (id_rs1_data),
    .rs2_data_o (id_rs2_data)
  );

  // inst and source indices are kept for waveform tracing only
  id_ex #(
    .RESET_PC (RESET_PC)
  ) u_id_ex (
    .clk        (clk),
    .rst_i      (rst_i),
    .hold_i     (hold),
    .flush_i    (flush),
    .valid_i    (id_valid),
    .pc_i       (id_pc),
    .inst_i     (id_inst),
    .rs1_idx_i  (id_rs1_idx),
    .rs2_idx_i  (id_rs2_idx),
    .rd_idx_i   (id_rd_idx),
    .imm_i      (id_imm),
    .rs1_data_i (id_rs1_data),
    .rs2_data_i (id_rs2_data),
    .alu_op_i   (id_alu_op),
    .pc_op_i    (id_pc_op),
    .illegal_i  (id_illegal),
    .valid_o    (ex_valid),
    .pc_o       (ex_pc),
    .inst_o     (),
    .rs1_idx_o  (),
    .rs2_idx_o  (),
    .rd_idx_o   (ex_rd_idx),
    .imm_o      (ex_imm),
    .rs1_data_o (ex_rs1_data),
    .rs2_data_o (ex_rs2_data),
    .alu_op_o   (ex_alu_op),
    .pc_op_o    (ex_pc_op),
    .illegal_o  (ex_illegal)
  );

  ex_stage u_ex_stage (
    .valid_i          (ex_valid),
    .stall_i          (ex_stall_i),
    .pc_i             (ex_pc),
    .rd_idx_i         (ex_rd_idx),
    .imm_i            (ex_imm),
    .rs1_data_i       (ex_rs1_data),
    .rs2_data_i       (ex_rs2_data),
    .alu_op_i         (ex_alu_op),
    .pc_op_i          (ex_pc_op),
    .illegal_i        (ex_illegal),
    .wb_valid_o       (wb_valid_o),
    .wb_rd_o          (wb_rd_o),
    .wb_data_o        (wb_data_o),
    .redirect_valid_o (redirect_valid_o),
    .redirect_pc_o    (redirect_pc_o),
    .trap_valid_o     (trap_valid_o),
    .trap_pc_o        (trap_pc_o)
  );

  hazard_ctrl u_hazard_ctrl (
    .ex_stall_i (ex_stall_i),
    .redirect_i (redirect_valid_o),
    .hold_o     (hold),
    .flush_o    (flush),
    .ready_o    (inst_ready_o)
  );

endmodule

`default_nettype wire

// File: design/ex_stage.sv
`timescale 1ns/1ns
`default_nettype none

module ex_stage (
  input  logic                  valid_i,
  input  logic                  stall_i,
  input  rv_core_pkg::xlen_t    pc_i,
  input  rv_core_pkg::reg_idx_t rd_idx_i,
  input  rv_core_pkg::xlen_t    imm_i,
  input  rv_core_pkg::xlen_t    rs1_data_i,
  input  rv_core_pkg::xlen_t    rs2_data_i,
  input  rv_core_pkg::alu_op_e  alu_op_i,
  input  rv_core_pkg::pc_op_e   pc_op_i,
  input  logic                  illegal_i,
  output logic                  wb_valid_o,
  output rv_core_pkg::reg_idx_t wb_rd_o,
  output rv_core_pkg::xlen_t    wb_data_o,
  output logic                  redirect_valid_o,
  output rv_core_pkg::xlen_t    redirect_pc_o,
  output logic                  trap_valid_o,
  output rv_core_pkg::xlen_t    trap_pc_o
);

  rv_core_pkg::xlen_t op_b;
  rv_core_pkg::xlen_t alu_res;
  logic               fire;
  logic               taken;

  always_comb begin
    // decode leaves rs2 at x0 for addi and imm at zero for register ops
    // so the or picks whichever operand is live
    op_b = rs2_data_i | imm_i;
    case (alu_op_i)
      rv_core_pkg::ALU_ADD: alu_res = rs1_data_i + op_b;
      rv_core_pkg::ALU_SUB: alu_res = rs1_data_i - op_b;
      rv_core_pkg::ALU_AND: alu_res = rs1_data_i & op_b;
      rv_core_pkg::ALU_OR:  alu_res = rs1_data_i | op_b;
      rv_core_pkg::ALU_XOR: alu_res = rs1_data_i ^ op_b;
      rv_core_pkg::ALU_SLT: alu_res = {31'b0, $signed(rs1_data_i) < $signed(op_b)};
      rv_core_pkg::ALU_LUI: alu_res = imm_i;
      default:              alu_res = '0;
    endcase

    // nothing leaves execute while back-pressured
    fire  = valid_i && !stall_i;
    taken = (pc_op_i == rv_core_pkg::PC_JAL) ||
            (pc_op_i == rv_core_pkg::PC_BEQ && rs1_data_i == rs2_data_i) ||
            (pc_op_i == rv_core_pkg::PC_BNE && rs1_data_i != rs2_data_i);

    // jal links pc plus 4, x0 writes are dropped
    wb_valid_o       = fire && !illegal_i && rd_idx_i != '0;
    wb_rd_o          = rd_idx_i;
    wb_data_o        = (pc_op_i == rv_core_pkg::PC_JAL) ? pc_i + 32'd4 : alu_res;
    redirect_valid_o = fire && taken;
    redirect_pc_o    = pc_i + imm_i;
    trap_valid_o     = fire && illegal_i;
    trap_pc_o        = pc_i;

    // decode gives illegal words no pc operation
    a_redirect_trap_excl: assert (!(redirect_valid_o && trap_valid_o))
      else $error("ex_stage: redirect and trap together");
  end

endmodule

`default_nettype wire

// File: design/hazard_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module hazard_ctrl (
  input  logic ex_stall_i,
  input  logic redirect_i,
  output logic hold_o,
  output logic flush_o,
  output logic ready_o
);

  always_comb begin
    // stall freezes id_ex and blocks fetch
    hold_o  = ex_stall_i;
    ready_o = !ex_stall_i;
    // redirect kills the word fetched in the same cycle
    // fetch stays ready so that word is taken and dropped
    flush_o = redirect_i && !ex_stall_i;
  end

endmodule

`default_nettype wire

// File: design/id_ex.sv
`timescale 1ns/1ns
`default_nettype none

module id_ex #(
  parameter rv_core_pkg::xlen_t RESET_PC = '0
) (
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  hold_i,
  input  logic                  flush_i,
  input  logic                  valid_i,
  input  rv_core_pkg::xlen_t    pc_i,
  input  rv_core_pkg::inst_t    inst_i,
  input  rv_core_pkg::reg_idx_t rs1_idx_i,
  input  rv_core_pkg::reg_idx_t rs2_idx_i,
  input  rv_core_pkg::reg_idx_t rd_idx_i,
  input  rv_core_pkg::xlen_t    imm_i,
  input  rv_core_pkg::xlen_t    rs1_data_i,
  input  rv_core_pkg::xlen_t    rs2_data_i,
  input  rv_core_pkg::alu_op_e  alu_op_i,
  input  rv_core_pkg::pc_op_e   pc_op_i,
  input  logic                  illegal_i,
  output logic                  valid_o,
  output rv_core_pkg::xlen_t    pc_o,
  output rv_core_pkg::inst_t    inst_o,
  output rv_core_pkg::reg_idx_t rs1_idx_o,
  output rv_core_pkg::reg_idx_t rs2_idx_o,
  output rv_core_pkg::reg_idx_t rd_idx_o,
  output rv_core_pkg::xlen_t    imm_o,
  output rv_core_pkg::xlen_t    rs1_data_o,
  output rv_core_pkg::xlen_t    rs2_data_o,
  output rv_core_pkg::alu_op_e  alu_op_o,
  output rv_core_pkg::pc_op_e   pc_op_o,
  output logic                  illegal_o
);

  logic take_bubble;

  // reset, flush or an empty fetch slot all load a bubble
  // hold wins over flush and empty slot
  assign take_bubble = rst_i || (!hold_i && (flush_i || !valid_i));

  always_ff @(posedge clk) begin
    if (take_bubble) begin
      valid_o    <= 1'b0;
      pc_o       <= RESET_PC;
      inst_o     <= rv_core_pkg::INST_NOP;
      rs1_idx_o  <= '0;
      rs2_idx_o  <= '0;
      rd_idx_o   <= '0;
      imm_o      <= '0;
      rs1_data_o <= '0;
      rs2_data_o <= '0;
      alu_op_o   <= rv_core_pkg::ALU_NONE;
      pc_op_o    <= rv_core_pkg::PC_NONE;
      illegal_o  <= 1'b0;
    end else if (!hold_i) begin
      valid_o    <= 1'b1;
      pc_o       <= pc_i;
      inst_o     <= inst_i;
      rs1_idx_o  <= rs1_idx_i;
      rs2_idx_o  <= rs2_idx_i;
      rd_idx_o   <= rd_idx_i;
      imm_o      <= imm_i;
      rs1_data_o <= rs1_data_i;
      rs2_data_o <= rs2_data_i;
      alu_op_o   <= alu_op_i;
      pc_op_o    <= pc_op_i;
      illegal_o  <= illegal_i;
    end
  end

  // hazard control must never ask for both at once
  a_hold_flush_excl: assert property (@(posedge clk) disable iff (rst_i)
    !(hold_i && flush_i))
    else $error("id_ex: hold and flush high together");

endmodule

`default_nettype wire

// File: design/id_stage.sv
`timescale 1ns/1ns
`default_nettype none

module id_stage (
  input  logic                  inst_valid_i,
  input  rv_core_pkg::xlen_t    inst_addr_i,
  input  rv_core_pkg::inst_t    inst_data_i,
  output logic                  valid_o,
  output rv_core_pkg::xlen_t    pc_o,
  output rv_core_pkg::inst_t    inst_o,
  output rv_core_pkg::reg_idx_t rs1_idx_o,
  output rv_core_pkg::reg_idx_t rs2_idx_o,
  output rv_core_pkg::reg_idx_t rd_idx_o,
  output rv_core_pkg::xlen_t    imm_o,
  output rv_core_pkg::alu_op_e  alu_op_o,
  output rv_core_pkg::pc_op_e   pc_op_o,
  output logic                  illegal_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       use_rs1;
  logic       use_rs2;
  logic       use_rd;

  assign opcode = inst_data_i[6:0];
  assign funct3 = inst_data_i[14:12];
  assign funct7 = inst_data_i[31:25];

  // fetch fields pass straight on
  assign valid_o = inst_valid_i;
  assign pc_o    = inst_addr_i;
  assign inst_o  = inst_data_i;

  always_comb begin
    // anything not matched below stays illegal
    alu_op_o  = rv_core_pkg::ALU_NONE;
    pc_op_o   = rv_core_pkg::PC_NONE;
    illegal_o = 1'b1;
    imm_o     = '0;
    use_rs1   = 1'b0;
    use_rs2   = 1'b0;
    use_rd    = 1'b0;
    case (opcode)
      rv_core_pkg::OPC_OP: begin
        case ({funct7, funct3})
          10'b0000000_000: alu_op_o = rv_core_pkg::ALU_ADD;
          10'b0100000_000: alu_op_o = rv_core_pkg::ALU_SUB;
          10'b0000000_111: alu_op_o = rv_core_pkg::ALU_AND;
          10'b0000000_110: alu_op_o = rv_core_pkg::ALU_OR;
          10'b0000000_100: alu_op_o = rv_core_pkg::ALU_XOR;
          10'b0000000_010: alu_op_o = rv_core_pkg::ALU_SLT;
          default:         alu_op_o = rv_core_pkg::ALU_NONE;
        endcase
        if (alu_op_o != rv_core_pkg::ALU_NONE) begin
          illegal_o = 1'b0;
          use_rs1   = 1'b1;
          use_rs2   = 1'b1;
          use_rd    = 1'b1;
        end
      end
      rv_core_pkg::OPC_OPIMM: begin
        // only addi of the op-imm group
        if (funct3 == 3'b000) begin
          alu_op_o  = rv_core_pkg::ALU_ADD;
          illegal_o = 1'b0;
          use_rs1   = 1'b1;
          use_rd    = 1'b1;
          imm_o     = {{20{inst_data_i[31]}}, inst_data_i[31:20]};
        end
      end
      rv_core_pkg::OPC_LUI: begin
        alu_op_o  = rv_core_pkg::ALU_LUI;
        illegal_o = 1'b0;
        use_rd    = 1'b1;
        imm_o     = {inst_data_i[31:12], 12'b0};
      end
      rv_core_pkg::OPC_BRANCH: begin
        // beq and bne, rd stays zero
        if (funct3 == 3'b000 || funct3 == 3'b001) begin
          pc_op_o   = funct3[0] ? rv_core_pkg::PC_BNE : rv_core_pkg::PC_BEQ;
          illegal_o = 1'b0;
          use_rs1   = 1'b1;
          use_rs2   = 1'b1;
          imm_o     = {{19{inst_data_i[31]}}, inst_data_i[31], inst_data_i[7],
                       inst_data_i[30:25], inst_data_i[11:8], 1'b0};
        end
      end
      rv_core_pkg::OPC_JAL: begin
        pc_op_o   = rv_core_pkg::PC_JAL;
        illegal_o = 1'b0;
        use_rd    = 1'b1;
        imm_o     = {{11{inst_data_i[31]}}, inst_data_i[31], inst_data_i[19:12],
                     inst_data_i[20], inst_data_i[30:21], 1'b0};
      end
      default: illegal_o = 1'b1;
    endcase
  end

  // unused sources read x0, so execute sees zero there
  assign rs1_idx_o = use_rs1 ? inst_data_i[19:15] : '0;
  assign rs2_idx_o = use_rs2 ? inst_data_i[24:20] : '0;
  assign rd_idx_o  = use_rd  ? inst_data_i[11:7]  : '0;

endmodule

`default_nettype wire

// File: design/reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
  input  logic                  clk,
  input  logic                  rst_i,
  input  rv_core_pkg::reg_idx_t rs1_idx_i,
  input  rv_core_pkg::reg_idx_t rs2_idx_i,
  input  logic                  we_i,
  input  rv_core_pkg::reg_idx_t wd_idx_i,
  input  rv_core_pkg::xlen_t    wd_data_i,
  output rv_core_pkg::xlen_t    rs1_data_o,
  output rv_core_pkg::xlen_t    rs2_data_o
);

  rv_core_pkg::xlen_t regs [32];

  // x0 is never written
  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && wd_idx_i != '0) begin
      regs[wd_idx_i] <= wd_data_i;
    end
  end

  // write-through so decode sees the value execute retires this cycle
  assign rs1_data_o = (rs1_idx_i == '0) ? '0 :
                      (we_i && wd_idx_i == rs1_idx_i) ? wd_data_i : regs[rs1_idx_i];
  assign rs2_data_o = (rs2_idx_i == '0) ? '0 :
                      (we_i && wd_idx_i == rs2_idx_i) ? wd_data_i : regs[rs2_idx_i];

endmodule

`default_nettype wire

// File: design/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

  // data and address width
  parameter int XLEN = 32;

  // register values, addresses and immediates
  typedef logic [XLEN-1:0] xlen_t;
  // raw instruction word
  typedef logic [31:0] inst_t;
  // architectural register index
  typedef logic [4:0] reg_idx_t;

  // addi x0, x0, 0
  parameter inst_t INST_NOP = 32'h0000_0013;

  // major opcodes of the supported subset
  parameter logic [6:0] OPC_OP     = 7'b0110011;
  parameter logic [6:0] OPC_OPIMM  = 7'b0010011;
  parameter logic [6:0] OPC_LUI    = 7'b0110111;
  parameter logic [6:0] OPC_BRANCH = 7'b1100011;
  parameter logic [6:0] OPC_JAL    = 7'b1101111;

  // alu operation selected by decode
  typedef enum logic [2:0] {
    ALU_NONE = 3'd0,
    ALU_ADD  = 3'd1,
    ALU_SUB  = 3'd2,
    ALU_AND  = 3'd3,
    ALU_OR   = 3'd4,
    ALU_XOR  = 3'd5,
    ALU_SLT  = 3'd6,
    ALU_LUI  = 3'd7
  } alu_op_e;

  // control transfer kind
  typedef enum logic [1:0] {
    PC_NONE = 2'd0,
    PC_BEQ  = 2'd1,
    PC_BNE  = 2'd2,
    PC_JAL  = 2'd3
  } pc_op_e;

endpackage

`default_nettype wire

// File: project.f
design/rv_core_pkg.sv
design/id_stage.sv
design/reg_file.sv
design/id_ex.sv
design/ex_stage.sv
design/hazard_ctrl.sv
design/core_id_ex_top.sv
verif/tb_top.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module tb_top -o tb_top_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_top_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Some tests failed" "$LOG"; then
  echo "simulation reported a failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
exit 0

// File: verif/tb_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_top;

  localparam int PROG_WORDS = 64;
  localparam logic [31:0] PROG_END = 32'd256;
  localparam int MAX_CYCLES = 4000;

  // instruction kinds as the model sees them
  localparam int K_ADD  = 0;
  localparam int K_SUB  = 1;
  localparam int K_AND  = 2;
  localparam int K_OR   = 3;
  localparam int K_XOR  = 4;
  localparam int K_SLT  = 5;
  localparam int K_ADDI = 6;
  localparam int K_LUI  = 7;
  localparam int K_BEQ  = 8;
  localparam int K_BNE  = 9;
  localparam int K_JAL  = 10;
  localparam int K_ILL  = 11;

  // kinds of expected events
  localparam int EV_WB    = 0;
  localparam int EV_REDIR = 1;
  localparam int EV_TRAP  = 2;

  logic                  clk = 1'b0;
  logic                  rst_i;
  logic                  inst_valid_i;
  rv_core_pkg::xlen_t    inst_addr_i;
  rv_core_pkg::inst_t    inst_data_i;
  logic                  ex_stall_i;
  logic                  inst_ready_o;
  logic                  wb_valid_o;
  rv_core_pkg::reg_idx_t wb_rd_o;
  rv_core_pkg::xlen_t    wb_data_o;
  logic                  redirect_valid_o;
  rv_core_pkg::xlen_t    redirect_pc_o;
  logic                  trap_valid_o;
  rv_core_pkg::xlen_t    trap_pc_o;

  // program image plus the fields the model runs from
  rv_core_pkg::inst_t    prog_word [PROG_WORDS];
  int                    prog_kind [PROG_WORDS];
  rv_core_pkg::reg_idx_t prog_rd   [PROG_WORDS];
  rv_core_pkg::reg_idx_t prog_rs1  [PROG_WORDS];
  rv_core_pkg::reg_idx_t prog_rs2  [PROG_WORDS];
  rv_core_pkg::xlen_t    prog_imm  [PROG_WORDS];

  // expected event stream in program order
  int          exp_kind [$];
  logic [31:0] exp_a [$];
  logic [31:0] exp_b [$];

  always #50 clk = ~clk;

  core_id_ex_top #(
    .RESET_PC (32'h0000_0000)
  ) dut (
    .clk              (clk),
    .rst_i            (rst_i),
    .inst_valid_i     (inst_valid_i),
    .inst_addr_i      (inst_addr_i),
    .inst_data_i      (inst_data_i),
    .ex_stall_i       (ex_stall_i),
    .inst_ready_o     (inst_ready_o),
    .wb_valid_o       (wb_valid_o),
    .wb_rd_o          (wb_rd_o),
    .wb_data_o        (wb_data_o),
    .redirect_valid_o (redirect_valid_o),
    .redirect_pc_o    (redirect_pc_o),
    .trap_valid_o     (trap_valid_o),
    .trap_pc_o        (trap_pc_o)
  );

  task automatic check_eq(string what, logic [31:0] got, logic [31:0] want);
    if (got !== want) begin
      $display("** Error at %0t ns: %s got %h expected %h", $time, what, got, want);
      $display("Some tests failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic fail_run(string reason);
    $display("%s at %0t ns", reason, $time);
    $display("Some tests failed");
    $fatal(1, "stopped on testbench failure");
  endtask

  function automatic rv_core_pkg::inst_t enc_r(logic [6:0] f7, rv_core_pkg::reg_idx_t rs2,
                                               rv_core_pkg::reg_idx_t rs1, logic [2:0] f3,
                                               rv_core_pkg::reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, rv_core_pkg::OPC_OP};
  endfunction

  // b-type scatters offset bits 12..1
  function automatic rv_core_pkg::inst_t enc_b(logic [31:0] off, rv_core_pkg::reg_idx_t rs2,
                                               rv_core_pkg::reg_idx_t rs1, logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_core_pkg::OPC_BRANCH};
  endfunction

  function automatic rv_core_pkg::inst_t enc_j(logic [31:0] off, rv_core_pkg::reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, rv_core_pkg::OPC_JAL};
  endfunction

  function automatic void push_event(int kind, logic [31:0] a, logic [31:0] b);
    exp_kind.push_back(kind);
    exp_a.push_back(a);
    exp_b.push_back(b);
  endfunction

  task automatic gen_program();
    int                    choice;
    int                    room;
    logic [11:0]           imm12;
    logic [19:0]           imm20;
    logic [31:0]           off;
    rv_core_pkg::reg_idx_t rd;
    rv_core_pkg::reg_idx_t rs1;
    rv_core_pkg::reg_idx_t rs2;
    for (int i = 0; i < PROG_WORDS; i++) begin
      choice = $urandom_range(0, 15);
      // few registers, so dependent pairs show up often
      rd   = 5'($urandom_range(0, 7));
      rs1  = 5'($urandom_range(0, 7));
      rs2  = 5'($urandom_range(0, 7));
      room = PROG_WORDS - 1 - i;
      // forward targets need at least two words left
      if (choice >= 10 && choice <= 12 && room < 2) begin
        choice = 6;
      end
      prog_imm[i] = '0;
      case (choice)
        0: begin
          prog_kind[i] = K_ADD;
          prog_word[i] = enc_r(7'h00, rs2, rs1, 3'b000, rd);
        end
        1: begin
          prog_kind[i] = K_SUB;
          prog_word[i] = enc_r(7'h20, rs2, rs1, 3'b000, rd);
        end
        2: begin
          prog_kind[i] = K_AND;
          prog_word[i] = enc_r(7'h00, rs2, rs1, 3'b111, rd);
        end
        3: begin
          prog_kind[i] = K_OR;
          prog_word[i] = enc_r(7'h00, rs2, rs1, 3'b110, rd);
        end
        4: begin
          prog_kind[i] = K_XOR;
          prog_word[i] = enc_r(7'h00, rs2, rs1, 3'b100, rd);
        end
        5: begin
          prog_kind[i] = K_SLT;
          prog_word[i] = enc_r(7'h00, rs2, rs1, 3'b010, rd);
        end
        9: begin
          imm20        = 20'($urandom);
          prog_kind[i] = K_LUI;
          prog_imm[i]  = {imm20, 12'b0};
          prog_word[i] = {imm20, rd, rv_core_pkg::OPC_LUI};
        end
        10, 11: begin
          // equal sources half the time so both outcomes occur
          if ($urandom_range(0, 1) == 0) begin
            rs2 = rs1;
          end
          off          = 32'($urandom_range(1, (room < 8) ? room : 8)) << 2;
          prog_kind[i] = (choice == 10) ? K_BEQ : K_BNE;
          prog_imm[i]  = off;
          prog_word[i] = enc_b(off, rs2, rs1, (choice == 10) ? 3'b000 : 3'b001);
        end
        12: begin
          off          = 32'($urandom_range(1, (room < 8) ? room : 8)) << 2;
          prog_kind[i] = K_JAL;
          prog_imm[i]  = off;
          prog_word[i] = enc_j(off, rd);
        end
        13: begin
          prog_kind[i] = K_ILL;
          // load opcode, mul, or slli
          case ($urandom_range(0, 2))
            0:       prog_word[i] = {25'($urandom), 7'b0000011};
            1:       prog_word[i] = enc_r(7'h01, rs2, rs1, 3'b000, rd);
            default: prog_word[i] = {12'h001, rs1, 3'b001, rd, rv_core_pkg::OPC_OPIMM};
          endcase
        end
        default: begin
          imm12        = 12'($urandom);
          prog_kind[i] = K_ADDI;
          prog_imm[i]  = {{20{imm12[11]}}, imm12};
          prog_word[i] = {imm12, rs1, 3'b000, rd, rv_core_pkg::OPC_OPIMM};
        end
      endcase
      prog_rd[i]  = rd;
      prog_rs1[i] = rs1;
      prog_rs2[i] = rs2;
    end
  endtask

  // instruction-level model, one step per instruction from address 0
  function automatic void run_model();
    logic [31:0] regs [32];
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic        writes;
    int          i;
    for (int r = 0; r < 32; r++) begin
      regs[r] = '0;
    end
    pc = '0;
    while (pc < PROG_END) begin
      i       = int'(pc >> 2);
      a       = regs[prog_rs1[i]];
      b       = regs[prog_rs2[i]];
      next_pc = pc + 32'd4;
      writes  = 1'b1;
      res     = '0;
      case (prog_kind[i])
        K_ADD:  res = a + b;
        K_SUB:  res = a - b;
        K_AND:  res = a & b;
        K_OR:   res = a | b;
        K_XOR:  res = a ^ b;
        K_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        K_ADDI: res = a + prog_imm[i];
        K_LUI:  res = prog_imm[i];
        K_BEQ, K_BNE: begin
          writes = 1'b0;
          if ((prog_kind[i] == K_BEQ) == (a == b)) begin
            next_pc = pc + prog_imm[i];
            push_event(EV_REDIR, next_pc, 32'd0);
          end
        end
        K_JAL: begin
          res     = pc + 32'd4;
          next_pc = pc + prog_imm[i];
        end
        default: begin
          writes = 1'b0;
          push_event(EV_TRAP, pc, 32'd0);
        end
      endcase
      // x0 keeps zero and its writes never show up
      if (writes && prog_rd[i] != 5'd0) begin
        regs[prog_rd[i]] = res;
        push_event(EV_WB, 32'(prog_rd[i]), res);
      end
      if (prog_kind[i] == K_JAL) begin
        push_event(EV_REDIR, next_pc, 32'd0);
      end
      pc = next_pc;
    end
  endfunction

  task automatic expect_event(int kind, logic [31:0] a, logic [31:0] b, string what);
    if (exp_kind.size() == 0) begin
      fail_run({"DUT signalled a ", what, " but the model has no events left"});
    end else begin
      check_eq({what, " event kind"}, kind, exp_kind[0]);
      check_eq({what, " first field"}, a, exp_a[0]);
      check_eq({what, " second field"}, b, exp_b[0]);
      void'(exp_kind.pop_front());
      void'(exp_a.pop_front());
      void'(exp_b.pop_front());
    end
  endtask

  initial begin
    logic [31:0] fetch_pc;
    logic        pending;
    logic        after_redir;
    int          cycles;
    int          tail;
    void'($urandom(77));
    rst_i        = 1'b1;
    inst_valid_i = 1'b0;
    inst_addr_i  = '0;
    inst_data_i  = '0;
    ex_stall_i   = 1'b0;
    fetch_pc     = '0;
    pending      = 1'b0;
    after_redir  = 1'b0;
    cycles       = 0;
    tail         = 0;
    gen_program();
    run_model();

    repeat (10) @(posedge clk);
    rst_i <= 1'b0;
    // pipeline empty out of reset
    @(negedge clk);
    check_eq("wb_valid_o after reset", 32'(wb_valid_o), 32'd0);
    check_eq("redirect_valid_o after reset", 32'(redirect_valid_o), 32'd0);
    check_eq("trap_valid_o after reset", 32'(trap_valid_o), 32'd0);
    check_eq("inst_ready_o after reset", 32'(inst_ready_o), 32'd1);

    while (tail < 4) begin
      @(posedge clk);
      // a word not yet taken stays on the bus
      if (!pending) begin
        if (fetch_pc < PROG_END && $urandom_range(0, 3) != 0) begin
          inst_valid_i <= 1'b1;
          inst_addr_i  <= fetch_pc;
          inst_data_i  <= prog_word[fetch_pc[7:2]];
        end else begin
          inst_valid_i <= 1'b0;
        end
      end
      // no back-pressure while draining
      ex_stall_i <= (fetch_pc < PROG_END) && ($urandom_range(0, 4) == 0);

      @(negedge clk);
      cycles++;
      if (cycles > MAX_CYCLES) begin
        fail_run("timeout while waiting for the program to retire");
      end
      if (ex_stall_i) begin
        check_eq("inst_ready_o during stall", 32'(inst_ready_o), 32'd0);
        check_eq("wb_valid_o during stall", 32'(wb_valid_o), 32'd0);
        check_eq("redirect_valid_o during stall", 32'(redirect_valid_o), 32'd0);
        check_eq("trap_valid_o during stall", 32'(trap_valid_o), 32'd0);
      end else begin
        check_eq("inst_ready_o without stall", 32'(inst_ready_o), 32'd1);
      end
      // slot behind a redirect was flushed
      if (after_redir) begin
        check_eq("wb_valid_o after redirect", 32'(wb_valid_o), 32'd0);
        check_eq("redirect_valid_o after redirect", 32'(redirect_valid_o), 32'd0);
        check_eq("trap_valid_o after redirect", 32'(trap_valid_o), 32'd0);
      end
      if (wb_valid_o) begin
        expect_event(EV_WB, 32'(wb_rd_o), wb_data_o, "writeback");
      end
      if (redirect_valid_o) begin
        expect_event(EV_REDIR, redirect_pc_o, 32'd0, "redirect");
      end
      if (trap_valid_o) begin
        expect_event(EV_TRAP, trap_pc_o, 32'd0, "trap");
      end
      after_redir = redirect_valid_o;
      pending     = inst_valid_i && !inst_ready_o;
      // follow a redirect, else step on each accepted word
      if (redirect_valid_o) begin
        fetch_pc = redirect_pc_o;
      end else if (inst_valid_i && inst_ready_o) begin
        fetch_pc = fetch_pc + 32'd4;
      end
      // a few idle cycles after the last word let it retire
      if (fetch_pc >= PROG_END) begin
        tail++;
      end
    end

    if (exp_kind.size() == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      fail_run("model events left unmatched at the end of the run");
    end
  end

endmodule

`default_nettype wire
